// File: Makefile
# Verilator build and run of the fetch front end testbench

OBJ = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f inst_fetch_top.f \
		--top-module tb_inst_fetch -Mdir $(OBJ)
	./$(OBJ)/Vtb_inst_fetch | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf $(OBJ) sim.log

// File: bench/tb_inst_fetch.sv
//**************************************************
// testbench of the fetch front end
// instruction memory model, reference predecode,
// scoreboard on the m_ side, random stalls and redirects
//**************************************************
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_inst_fetch
	import fetch_pkg::*;
();

	logic      aclk;
	logic      aresetn;
	logic      ibus_req_valid;
	pc_t       ibus_req_addr;
	ibus_tid_t ibus_req_tid;
	logic      ibus_rsp_valid;
	inst_t     ibus_rsp_data;
	ibus_err_t ibus_rsp_err;
	ibus_tid_t ibus_rsp_tid;
	logic      redirect_valid;
	pc_t       redirect_pc;
	logic      sys_reset_req;
	logic      m_valid;
	logic      m_ready;
	pc_t       m_pc;
	inst_t     m_inst;
	predec_t   m_predec;
	logic      m_illegal;
	ibus_err_t m_err;
	logic      m_pred_taken;
	pc_t       m_pred_target;
	ibus_tid_t m_tid;
	logic      m_first_after_rst;

	integer    seed;
	integer    cycle = 0;
	integer    xfer_count = 0;
	integer    firsts_seen = 0;
	integer    error_count = 0;
	integer    last_due = 0;
	pc_t       pend_addr[$];       // requests not yet answered
	ibus_tid_t pend_tid[$];
	integer    pend_due[$];
	pc_t       exp_pc;             // scoreboard pc
	logic      live;               // in-flight request not flushed
	ibus_tid_t live_tid;
	logic      first_pending;      // next accepted word is first
	logic      entry_first;
	ibus_tid_t entry_tid;          // id of the word in the stage

	inst_fetch_top inst_fetch_top_i (.*);

	initial
	begin
		aclk = 1'b0;
		forever
			#5 aclk = ~aclk;
	end

	// opcode picked by the low hash nibble
	function automatic inst_t mem_word(input pc_t a);
		logic [31:0] h;
		logic [6:0]  opc;
		inst_t       w;
		h = a * 32'h9e3779b1;
		h = h ^ (h >> 15);
		h = h * 32'h85ebca6b;
		h = h ^ (h >> 13);
		case (h[3:0])
			4'd0, 4'd1, 4'd2: opc = `OPC_BRANCH;
			4'd3, 4'd4:       opc = `OPC_JAL;
			4'd5:  opc = `OPC_JALR;
			4'd6:  opc = `OPC_LOAD;
			4'd7:  opc = `OPC_STORE;
			4'd8:  opc = `OPC_OP;
			4'd9:  opc = `OPC_OP_IMM;
			4'd10: opc = `OPC_LUI;
			4'd11: opc = `OPC_AUIPC;
			4'd12: opc = `OPC_SYSTEM;
			4'd13: opc = `OPC_FENCE;
			4'd14: opc = 7'b0000000;     // low bits not 11
			default: opc = 7'b1011011;   // unused major opcode
		endcase
		w = {h[31:7], opc};   // bit 31 gives the offset sign
		if (opc == `OPC_BRANCH)
			w[8] = 1'b0;      // keep targets word aligned
		if (opc == `OPC_JAL)
			w[21] = 1'b0;
		return w;
	endfunction

	function automatic ibus_err_t mem_err(input pc_t a);
		return (a >= 32'h3000 && a <= 32'h30ff) ? 2'd1 : 2'd0;   // fault window
	endfunction

	// expected predecode and prediction of the word at pc
	function automatic void expect_predecode(input pc_t pc, output inst_t w,
		output predec_t cls, output logic ill, output ibus_err_t err, output logic taken,
		output pc_t target, output pc_t next);
		logic [6:0] opc;
		pc_t        boff;
		pc_t        joff;
		w = mem_word(pc);
		err = mem_err(pc);
		opc = w[6:0];
		cls = (opc == `OPC_BRANCH) ? 4'b0001 : (opc == `OPC_JAL) ? 4'b0010 :
			(opc == `OPC_JALR) ? 4'b0100 : 4'b1000;
		ill = !(opc inside {`OPC_BRANCH, `OPC_JAL, `OPC_JALR, `OPC_LOAD, `OPC_STORE,
			`OPC_OP, `OPC_OP_IMM, `OPC_LUI, `OPC_AUIPC, `OPC_SYSTEM, `OPC_FENCE})
			|| (w[1:0] != 2'b11);
		boff = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		joff = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		if (cls[1])
			target = pc + joff;
		else if (cls[0])
			target = pc + boff;
		else
			target = pc + 32'd4;
		taken = (err == 2'd0) && (cls[1] || (cls[0] && w[31]));   // backward or jal
		next = taken ? target : pc + 32'd4;
	endfunction

	task automatic fail_run(input string why);
		error_count = error_count + 1;
		$display("ERROR at %0t: %s", $time, why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			error_count = error_count + 1;
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// memory answers in order with at most one response per cycle
	always @(posedge aclk)
	begin
		cycle = cycle + 1;
		#1;
		if (pend_due.size() > 0 && pend_due[0] <= cycle)
		begin
			ibus_rsp_valid = 1'b1;
			ibus_rsp_data = mem_word(pend_addr[0]);
			ibus_rsp_err = mem_err(pend_addr[0]);
			ibus_rsp_tid = pend_tid[0];
			void'(pend_addr.pop_front());
			void'(pend_tid.pop_front());
			void'(pend_due.pop_front());
		end
		else
			ibus_rsp_valid = 1'b0;
	end

	// monitor and scoreboard sampled mid cycle
	always @(negedge aclk)
	begin : monitor
		inst_t     w;
		predec_t   cls;
		logic      ill;
		ibus_err_t err;
		logic      taken;
		pc_t       target;
		pc_t       next;
		inst_t     lat_hash;
		integer    due;
		if (aresetn)
		begin
			if (ibus_rsp_valid && live && ibus_rsp_tid == live_tid
				&& !(redirect_valid || sys_reset_req))
			begin
				check_val("m_valid at live response", m_valid, 0);   // room in stage
				entry_first = first_pending;
				entry_tid = ibus_rsp_tid;
				first_pending = 1'b0;
				live = 1'b0;
			end
			if (ibus_req_valid)
			begin
				check_val("ibus_req_addr", ibus_req_addr, exp_pc);
				foreach (pend_tid[i])
					if (pend_tid[i] == ibus_req_tid)
						fail_run("request id reused while a stale response is in flight");
				lat_hash = mem_word(ibus_req_addr ^ cycle);
				due = cycle + 1 + lat_hash[8:7];       // 1 to 4 cycles
				if (due <= last_due)
					due = last_due + 1;
				pend_addr.push_back(ibus_req_addr);
				pend_tid.push_back(ibus_req_tid);
				pend_due.push_back(due);
				last_due = due;
				live = 1'b1;
				live_tid = ibus_req_tid;
			end
			if (m_valid && m_ready)
			begin
				expect_predecode(exp_pc, w, cls, ill, err, taken, target, next);
				check_val("m_pc", m_pc, exp_pc);
				check_val("m_inst", m_inst, w);
				check_val("m_predec", m_predec, cls);
				check_val("m_illegal", m_illegal, ill);
				check_val("m_err", m_err, err);
				check_val("m_pred_taken", m_pred_taken, taken);
				check_val("m_pred_target", m_pred_target, target);
				check_val("m_tid", m_tid, entry_tid);
				check_val("m_first_after_rst", m_first_after_rst, entry_first);
				if (m_first_after_rst)
					firsts_seen = firsts_seen + 1;
				exp_pc = next;
				xfer_count = xfer_count + 1;
			end
			if (sys_reset_req)
			begin
				exp_pc = `RESET_PC;
				first_pending = 1'b1;
				live = 1'b0;
			end
			else if (redirect_valid)
			begin
				exp_pc = redirect_pc;
				live = 1'b0;     // its response is stale now
			end
		end
	end

	// run n more transfers with optional stalls and redirects
	task automatic run_phase(input integer n, input logic rand_ready, input logic use_redir);
		integer target;
		integer last;
		integer idle;
		integer stretch;
		integer r;
		target = xfer_count + n;
		last = xfer_count;
		idle = 0;
		stretch = 0;
		while (xfer_count < target)
		begin
			@(posedge aclk);
			#1;
			if (rand_ready && stretch == 0)
			begin
				r = $random(seed);
				m_ready = (r[2:0] != 3'd0) ? r[3] : 1'b0;
				stretch = 1 + r[8:4];                // up to 32 cycles
			end
			else if (!rand_ready)
				m_ready = 1'b1;
			if (stretch > 0)
				stretch = stretch - 1;
			r = $random(seed);
			redirect_valid = use_redir && (r[5:0] == 6'd0);
			redirect_pc = r[31] ? (32'h3000 | (r & 32'hfc)) : (r & 32'h0000_fffc);
			if (xfer_count != last)
			begin
				last = xfer_count;
				idle = 0;
			end
			else
				idle = idle + 1;
			if (idle > 300)
				fail_run("no transfer on the fetch output for 300 cycles");
		end
		redirect_valid = 1'b0;
	endtask

	initial
	begin
		seed = 32'hba711313;
		aresetn = 1'b0;
		ibus_rsp_valid = 1'b0;
		ibus_rsp_data = '0;
		ibus_rsp_err = '0;
		ibus_rsp_tid = '0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		sys_reset_req = 1'b0;
		m_ready = 1'b0;
		exp_pc = `RESET_PC;
		live = 1'b0;
		live_tid = '0;
		first_pending = 1'b1;
		entry_first = 1'b0;
		entry_tid = '0;
		repeat (16)
			@(posedge aclk);
		#1;
		check_val("ibus_req_valid in reset", ibus_req_valid, 0);
		check_val("m_valid in reset", m_valid, 0);
		aresetn = 1'b1;
		run_phase(40, 1'b0, 1'b0);
		run_phase(400, 1'b1, 1'b1);
		@(posedge aclk);
		#1;
		m_ready = 1'b1;
		sys_reset_req = 1'b1;    // soft restart for three cycles
		repeat (3)
			@(posedge aclk);
		#1;
		sys_reset_req = 1'b0;
		run_phase(30, 1'b0, 1'b0);
		check_val("first flags seen", firsts_seen, 2);
		if (error_count == 0)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
		begin
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule

// File: inst_fetch_top.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/pc_gen.sv
rtl/inst_predecode.sv
rtl/if_regs.sv
rtl/inst_fetch_top.sv
bench/tb_inst_fetch.sv

// File: rtl/fetch_consts.svh
//**************************************************
// fetch front end constants
// reset vector, bus id width and the RV32I opcodes
// included by the package and by modules using them
//**************************************************
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define RESET_PC        32'h0000_0100   // restart address
`define IBUS_TID_WIDTH  4               // bus transaction id bits

`define OPC_BRANCH  7'b1100011  // conditional branches
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP      7'b0110011  // reg-reg alu
`define OPC_OP_IMM  7'b0010011  // reg-imm alu
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_SYSTEM  7'b1110011
`define OPC_FENCE   7'b0001111

`endif

// File: rtl/fetch_ctrl.sv
//**************************************************
// fetch control FSM
// issues one word fetch at a time on the instruction bus,
// matches responses by id and restarts on flush
//**************************************************
`timescale 1ns/1ps

module fetch_ctrl
	import fetch_pkg::*;
(
	input  logic      aclk,
	input  logic      aresetn,
	input  logic      sys_reset_req,    // level, soft restart
	input  logic      redirect_valid,   // strobe from execute
	input  logic      ibus_rsp_valid,
	input  ibus_tid_t ibus_rsp_tid,
	input  pc_t       fetch_pc,         // address of the next fetch
	input  logic      stage_free,       // stage empty or draining
	output logic      ibus_req_valid,
	output pc_t       ibus_req_addr,
	output ibus_tid_t ibus_req_tid,
	output logic      rsp_accept,       // response goes into the stage
	output logic      flush,
	output logic      first_after_rst
);

	fetch_state_e state;
	fetch_state_e state_nxt;
	ibus_tid_t    tid_q;       // id of request in flight or next out
	logic         busy_q;      // a request is outstanding
	logic         first_q;     // no response taken since restart
	logic         req_fire;

	assign flush = redirect_valid | sys_reset_req;
	assign req_fire = (state == ISSUE);   // moore strobe

	assign ibus_req_valid = req_fire;
	assign ibus_req_addr = fetch_pc;
	assign ibus_req_tid = tid_q;

	// only the in-flight id is taken, stale ones fall through
	assign rsp_accept = busy_q & ibus_rsp_valid & (ibus_rsp_tid == tid_q) & ~flush;
	assign first_after_rst = first_q;

	always_comb
	begin
		state_nxt = state;
		if (sys_reset_req)
			state_nxt = IDLE;           // hold until the level drops
		else if (redirect_valid)
			state_nxt = ISSUE;          // refetch next cycle
		else
		begin
			case (state)
				IDLE:
					state_nxt = ISSUE;  // stage empty after any reset
				ISSUE:
					state_nxt = WAIT;
				WAIT:
					if (rsp_accept)
						state_nxt = DRAIN;
				DRAIN:
					if (stage_free)
						state_nxt = ISSUE;
				default:
					state_nxt = IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// bump on flush so a late response no longer matches
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			tid_q <= '0;
		else if (flush | rsp_accept)
			tid_q <= tid_q + 1'b1;
	end

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			busy_q <= 1'b0;
		else if (flush)
			busy_q <= 1'b0;     // abandon in-flight request
		else if (req_fire)
			busy_q <= 1'b1;
		else if (rsp_accept)
			busy_q <= 1'b0;
	end

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			first_q <= 1'b1;
		else if (sys_reset_req)
			first_q <= 1'b1;    // soft restart counts as reset
		else if (rsp_accept)
			first_q <= 1'b0;
	end

	// the stage must have room when issuing and when the word comes back
	a_room_for_rsp: assert property (@(posedge aclk) disable iff (!aresetn)
		(req_fire | rsp_accept) |-> stage_free);

	// single outstanding request on the bus
	a_one_in_flight: assert property (@(posedge aclk) disable iff (!aresetn)
		req_fire |-> !busy_q);

endmodule

// File: rtl/fetch_pkg.sv
//**************************************************
// shared types of the fetch front end
// imported by every fetch module and the testbench
//**************************************************
`include "fetch_consts.svh"

package fetch_pkg;

	// byte address of an instruction
	typedef logic [31:0] pc_t;

	// raw instruction word as returned by the bus
	typedef logic [31:0] inst_t;

	// bus transaction id, stale responses are told apart by it
	typedef logic [`IBUS_TID_WIDTH-1:0] ibus_tid_t;

	// access error code
	// 0 ok, 1 bus fault, 2 misaligned
	typedef logic [1:0] ibus_err_t;

	// one-hot predecode class
	// bit 0 branch, bit 1 jal, bit 2 jalr, bit 3 anything else
	typedef logic [3:0] predec_t;

	// fetch control states
	typedef enum logic [1:0] {
		IDLE,   // after reset, stage known empty
		ISSUE,  // request on the bus this cycle
		WAIT,   // one request in flight
		DRAIN   // entry written, waiting for room
	} fetch_state_e;

endpackage

// File: rtl/if_regs.sv
//**************************************************
// one-entry fetch stage register
// filled by an accepted response, drained by decode
// through valid/ready, cleared by flush
//**************************************************
`timescale 1ns/1ps

module if_regs
	import fetch_pkg::*;
(
	input  logic      aclk,
	input  logic      aresetn,
	input  logic      flush,
	input  logic      wr_valid,        // write strobe from control
	input  pc_t       wr_pc,
	input  inst_t     wr_inst,
	input  predec_t   wr_predec,
	input  logic      wr_illegal,
	input  ibus_err_t wr_err,
	input  logic      wr_pred_taken,
	input  pc_t       wr_pred_target,
	input  ibus_tid_t wr_tid,
	input  logic      wr_first,
	output logic      stage_free,      // empty or draining
	output logic      m_valid,
	input  logic      m_ready,
	output pc_t       m_pc,
	output inst_t     m_inst,
	output predec_t   m_predec,
	output logic      m_illegal,
	output ibus_err_t m_err,
	output logic      m_pred_taken,
	output pc_t       m_pred_target,
	output ibus_tid_t m_tid,
	output logic      m_first_after_rst
);

	logic stage_valid;

	assign stage_free = ~stage_valid | m_ready;
	assign m_valid = stage_valid & ~flush;   // no transfer during flush

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			stage_valid <= 1'b0;
		else if (flush)
			stage_valid <= 1'b0;
		else if (stage_free)
			stage_valid <= wr_valid;         // refill or go empty
	end

	// payload only, valid alone qualifies it
	always_ff @(posedge aclk)
	begin
		if (wr_valid & stage_free)
		begin
			m_pc <= wr_pc;
			m_inst <= wr_inst;
			m_predec <= wr_predec;
			m_illegal <= wr_illegal;
			m_err <= wr_err;
			m_pred_taken <= wr_pred_taken;
			m_pred_target <= wr_pred_target;
			m_tid <= wr_tid;
			m_first_after_rst <= wr_first;
		end
	end

	// control must only write when an entry can be taken
	a_no_overrun: assert property (@(posedge aclk) disable iff (!aresetn)
		wr_valid |-> stage_free);

endmodule

// File: rtl/inst_fetch_top.sv
//**************************************************
// instruction fetch front end
// bus master on the instruction bus, valid/ready
// output towards decode
//**************************************************
`timescale 1ns/1ps

module inst_fetch_top
	import fetch_pkg::*;
(
	input  logic      aclk,
	input  logic      aresetn,
	output logic      ibus_req_valid,
	output pc_t       ibus_req_addr,
	output ibus_tid_t ibus_req_tid,
	input  logic      ibus_rsp_valid,
	input  inst_t     ibus_rsp_data,
	input  ibus_err_t ibus_rsp_err,
	input  ibus_tid_t ibus_rsp_tid,
	input  logic      redirect_valid,
	input  pc_t       redirect_pc,
	input  logic      sys_reset_req,
	output logic      m_valid,
	input  logic      m_ready,
	output pc_t       m_pc,
	output inst_t     m_inst,
	output predec_t   m_predec,
	output logic      m_illegal,
	output ibus_err_t m_err,
	output logic      m_pred_taken,
	output pc_t       m_pred_target,
	output ibus_tid_t m_tid,
	output logic      m_first_after_rst
);

	pc_t     fetch_pc;
	logic    stage_free;
	logic    rsp_accept;
	logic    flush;
	logic    first_after_rst;
	predec_t predec;
	logic    illegal;
	logic    pred_taken;
	pc_t     pred_target;
	pc_t     pred_next_pc;

	fetch_ctrl fetch_ctrl_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.sys_reset_req(sys_reset_req),
		.redirect_valid(redirect_valid),
		.ibus_rsp_valid(ibus_rsp_valid),
		.ibus_rsp_tid(ibus_rsp_tid),
		.fetch_pc(fetch_pc),
		.stage_free(stage_free),
		.ibus_req_valid(ibus_req_valid),
		.ibus_req_addr(ibus_req_addr),
		.ibus_req_tid(ibus_req_tid),
		.rsp_accept(rsp_accept),
		.flush(flush),
		.first_after_rst(first_after_rst)
	);

	pc_gen pc_gen_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.sys_reset_req(sys_reset_req),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.rsp_accept(rsp_accept),
		.pred_next_pc(pred_next_pc),
		.fetch_pc(fetch_pc)
	);

	// decodes the word on the bus in the cycle it arrives
	inst_predecode inst_predecode_i (
		.fetch_pc(fetch_pc),
		.inst(ibus_rsp_data),
		.err(ibus_rsp_err),
		.predec(predec),
		.illegal(illegal),
		.pred_taken(pred_taken),
		.pred_target(pred_target),
		.pred_next_pc(pred_next_pc)
	);

	if_regs if_regs_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.flush(flush),
		.wr_valid(rsp_accept),
		.wr_pc(fetch_pc),
		.wr_inst(ibus_rsp_data),
		.wr_predec(predec),
		.wr_illegal(illegal),
		.wr_err(ibus_rsp_err),
		.wr_pred_taken(pred_taken),
		.wr_pred_target(pred_target),
		.wr_tid(ibus_rsp_tid),
		.wr_first(first_after_rst),
		.stage_free(stage_free),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.m_pc(m_pc),
		.m_inst(m_inst),
		.m_predec(m_predec),
		.m_illegal(m_illegal),
		.m_err(m_err),
		.m_pred_taken(m_pred_taken),
		.m_pred_target(m_pred_target),
		.m_tid(m_tid),
		.m_first_after_rst(m_first_after_rst)
	);

endmodule

// File: rtl/inst_predecode.sv
//**************************************************
// predecode and static branch prediction
// combinational on the returned word and its fetch PC,
// backward branches and JAL predicted taken
//**************************************************
`timescale 1ns/1ps
`include "fetch_consts.svh"

module inst_predecode
	import fetch_pkg::*;
(
	input  pc_t       fetch_pc,
	input  inst_t     inst,
	input  ibus_err_t err,
	output predec_t   predec,        // one-hot class
	output logic      illegal,
	output logic      pred_taken,
	output pc_t       pred_target,   // jump target or pc+4
	output pc_t       pred_next_pc
);

	logic [6:0] opcode;
	logic       opc_legal;
	logic       is_branch;
	logic       is_jal;
	pc_t        b_imm;
	pc_t        j_imm;
	pc_t        seq_pc;

	assign opcode = inst[6:0];

	always_comb
	begin
		opc_legal = 1'b1;
		predec = 4'b1000;               // default other
		case (opcode)
			`OPC_BRANCH:
				predec = 4'b0001;
			`OPC_JAL:
				predec = 4'b0010;
			`OPC_JALR:
				predec = 4'b0100;       // target unknown here
			`OPC_LOAD, `OPC_STORE, `OPC_OP, `OPC_OP_IMM,
			`OPC_LUI, `OPC_AUIPC, `OPC_SYSTEM, `OPC_FENCE:
				predec = 4'b1000;
			default:
				opc_legal = 1'b0;
		endcase
	end

	// compressed encodings are not supported
	assign illegal = ~opc_legal | (inst[1:0] != 2'b11);

	assign is_branch = predec[0];
	assign is_jal = predec[1];

	// sign extended offsets, bit 0 always zero
	assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign seq_pc = fetch_pc + 32'd4;

	always_comb
	begin
		if (is_jal)
			pred_target = fetch_pc + j_imm;
		else if (is_branch)
			pred_target = fetch_pc + b_imm;
		else
			pred_target = seq_pc;        // no static target
	end

	// taken for any jal or a backward branch, never on a bus error
	assign pred_taken = (err == 2'd0) & (is_jal | (is_branch & b_imm[31]));

	assign pred_next_pc = pred_taken ? pred_target : seq_pc;

endmodule

// File: rtl/pc_gen.sv
//**************************************************
// fetch PC register
// picks system reset, redirect or predicted next PC
//**************************************************
`timescale 1ns/1ps
`include "fetch_consts.svh"

module pc_gen
	import fetch_pkg::*;
(
	input  logic aclk,
	input  logic aresetn,
	input  logic sys_reset_req,
	input  logic redirect_valid,
	input  pc_t  redirect_pc,      // target from execute
	input  logic rsp_accept,       // current fetch returned
	input  pc_t  pred_next_pc,     // from predecode
	output pc_t  fetch_pc
);

	pc_t pc_nxt;

	// priority reset > redirect > prediction
	always_comb
	begin
		pc_nxt = fetch_pc;
		if (sys_reset_req)
			pc_nxt = `RESET_PC;
		else if (redirect_valid)
			pc_nxt = redirect_pc;
		else if (rsp_accept)
			pc_nxt = pred_next_pc;    // follow static prediction
	end

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			fetch_pc <= `RESET_PC;
		else
			fetch_pc <= pc_nxt;
	end

	// redirect targets and predicted targets must keep word alignment
	a_pc_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
		fetch_pc[1:0] == 2'b00);

endmodule
